/* Bender.yml */
package:
  name: branch_unit

sources:
  - files:
      - hdl/branch_pkg.sv
      - hdl/branch_config.sv
      - hdl/branch_detector.sv
      - hdl/branch_arbiter.sv
      - hdl/branch_unit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/branch_unit_tb.sv

/* flist.f */
+incdir+test
hdl/branch_pkg.sv
hdl/branch_config.sv
hdl/branch_detector.sv
hdl/branch_arbiter.sv
hdl/branch_unit.sv
test/branch_unit_tb.sv

/* hdl/branch_arbiter.sv */
// Priority arbiter over the branch detector outcomes
// Stage 0 grants the lowest jumping index and registers everything
// Stage 1 selects the cancel bit and the destination with the grant
// Stage 1 is combinational and the consumer registers it

`timescale 1ns/100ps

module branch_arbiter (
    input  logic                            clock,
    input  logic                            arst_n,
    input  branch_pkg::branch_req_t         reqs [branch_pkg::branch_count],
    output logic                            jump,
    output logic                            cancel,
    output logic [branch_pkg::pc_width-1:0] jump_destination
);

    // --------------------
    // Stage 0
    logic [branch_pkg::branch_count-1:0]  jumps;
    logic [branch_pkg::branch_count-1:0]  cancels;
    logic [branch_pkg::pc_width-1:0]      destinations [branch_pkg::branch_count];
    logic                                 jumps_any;
    logic [branch_pkg::outcome_count-1:0] jumps_all;
    logic [branch_pkg::outcome_count-1:0] grant;
    logic [branch_pkg::outcome_count-1:0] cancels_all;

    always_comb begin
        for (int i = 0; i < branch_pkg::branch_count; i++) begin
            jumps[i]        = reqs[i].jump;
            cancels[i]      = reqs[i].cancel;
            destinations[i] = reqs[i].destination;
        end
    end

    // The no-jump request sits at the top, so it only wins when nothing
    // else asks and the grant is never empty
    assign jumps_any = |jumps;
    assign jumps_all = {!jumps_any, jumps};

    // Isolate the lowest set bit, which is the highest priority request
    assign grant = jumps_all & (~jumps_all + 1'b1);

    // With no jump, any misprediction still cancels the concurrent instruction
    assign cancels_all = {|cancels, cancels};

    // --------------------
    // Stage 0 registers
    logic [branch_pkg::outcome_count-1:0] grant_q;
    logic [branch_pkg::outcome_count-1:0] cancels_all_q;
    logic [branch_pkg::pc_width-1:0]      destinations_q [branch_pkg::branch_count];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            jump          <= 1'b0;
            grant_q       <= '0;
            cancels_all_q <= '0;
        end else begin
            jump          <= jumps_any;
            grant_q       <= grant;
            cancels_all_q <= cancels_all;
        end
    end

    // Every detector's destination is captured each cycle for stage 1 to pick from
    always_ff @(posedge clock) begin
        destinations_q <= destinations;
    end

    // --------------------
    // Stage 1
    // The full grant picks the cancel bit, including the no-jump slot
    assign cancel = |(grant_q & cancels_all_q);

    // Dropping the no-jump slot from the grant leaves no select bit set
    // when nothing jumps, so the destination falls to zero
    always_comb begin
        jump_destination = '0;
        for (int i = 0; i < branch_pkg::branch_count; i++) begin
            jump_destination = jump_destination
                             | (destinations_q[i] & {branch_pkg::pc_width{grant_q[i]}});
        end
    end

endmodule

/* hdl/branch_config.sv */
// Descriptor register block behind a Wishbone classic slave port
// Holds one descriptor per branch detector and drives them all in parallel
// Two-cycle accesses with a single-cycle ack, full-word only

`timescale 1ns/100ps

module branch_config (
    input  logic                    clock,
    input  logic                    arst_n,
    input  branch_pkg::wb_req_t     wb_req,
    output branch_pkg::wb_rsp_t     wb_rsp,
    output branch_pkg::branch_cfg_t cfgs [branch_pkg::branch_count]
);

    // --------------------
    // Address decode
    logic [branch_pkg::branch_index_width-1:0] branch_index;
    logic [branch_pkg::field_width-1:0]        field;
    logic                                      access;
    logic                                      ack_q;
    logic [branch_pkg::wb_data_width-1:0]      read_data;

    assign branch_index = wb_req.adr[branch_pkg::field_width +: branch_pkg::branch_index_width];
    assign field        = wb_req.adr[branch_pkg::field_width-1:0];

    // A new access starts when the master strobes and no ack is pending.
    // Holding ack for one cycle only lets a held strobe restart an access
    // on the cycle after the ack
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // --------------------
    // Descriptor registers
    // Writes land on the edge that raises ack, so the detectors see the
    // new descriptor in the following cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // All zero means every branch is disabled
            cfgs <= '{default: '0};
        end else if (access && wb_req.we) begin
            case (field)
                branch_pkg::field_origin: begin
                    cfgs[branch_index].origin <= wb_req.dat[branch_pkg::pc_width-1:0];
                end
                branch_pkg::field_destination: begin
                    cfgs[branch_index].destination <= wb_req.dat[branch_pkg::pc_width-1:0];
                end
                branch_pkg::field_control: begin
                    cfgs[branch_index].enable <= wb_req.dat[branch_pkg::ctrl_enable_bit];
                    cfgs[branch_index].predict_taken <=
                        wb_req.dat[branch_pkg::ctrl_predict_bit];
                    cfgs[branch_index].condition <=
                        branch_pkg::cond_e'(wb_req.dat[branch_pkg::cond_width-1:0]);
                end
                // Field 3 is unused and drops the write
                default: begin
                end
            endcase
        end
    end

    // --------------------
    // Read path
    // The master holds the address until ack, so a plain mux of the
    // current registers is valid for the whole ack cycle
    always_comb begin
        read_data = '0;
        case (field)
            branch_pkg::field_origin: begin
                read_data[branch_pkg::pc_width-1:0] = cfgs[branch_index].origin;
            end
            branch_pkg::field_destination: begin
                read_data[branch_pkg::pc_width-1:0] = cfgs[branch_index].destination;
            end
            branch_pkg::field_control: begin
                read_data[branch_pkg::ctrl_enable_bit]  = cfgs[branch_index].enable;
                read_data[branch_pkg::ctrl_predict_bit] = cfgs[branch_index].predict_taken;
                read_data[branch_pkg::cond_width-1:0]   = cfgs[branch_index].condition;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        wb_rsp.ack = ack_q;
        wb_rsp.dat = read_data;
    end

endmodule

/* hdl/branch_detector.sv */
// Single branch detector
// Matches the PC against one descriptor and tests its condition
// Produces the jump, the misprediction cancel and the destination

`timescale 1ns/100ps

module branch_detector (
    input  branch_pkg::branch_cfg_t cfg,
    input  logic [branch_pkg::pc_width-1:0] pc,
    input  branch_pkg::alu_flags_t  flags,
    output branch_pkg::branch_req_t req
);

    logic match;
    logic cond_true;

    // --------------------
    // Condition evaluation
    always_comb begin
        case (cfg.condition)
            branch_pkg::cond_always: begin
                cond_true = 1'b1;
            end
            branch_pkg::cond_zero: begin
                cond_true = flags.zero;
            end
            branch_pkg::cond_not_zero: begin
                cond_true = !flags.zero;
            end
            branch_pkg::cond_negative: begin
                cond_true = flags.negative;
            end
            branch_pkg::cond_not_negative: begin
                cond_true = !flags.negative;
            end
            branch_pkg::cond_carry: begin
                cond_true = flags.carry;
            end
            branch_pkg::cond_not_carry: begin
                cond_true = !flags.carry;
            end
            branch_pkg::cond_overflow: begin
                cond_true = flags.overflow;
            end
            default: begin
                cond_true = 1'b0;
            end
        endcase
    end

    // --------------------
    // Outcome
    // Only an enabled descriptor at its origin PC takes part
    assign match = cfg.enable && (pc == cfg.origin);

    always_comb begin
        req.jump        = match && cond_true;
        // The concurrent instruction was fetched on the predicted path,
        // so it must go whenever the real outcome disagrees
        req.cancel      = match && (cond_true != cfg.predict_taken);
        req.destination = cfg.destination;
    end

endmodule

/* hdl/branch_pkg.sv */
// Shared definitions for the branch unit
// Sizes of the PC, the detector array and the Wishbone port
// Condition opcodes and the ALU flag, descriptor and request types
// Wishbone classic request and response types
// Register map of the descriptor fields

package branch_pkg;

    // --------------------
    // Sizes
    localparam int unsigned pc_width           = 10;
    localparam int unsigned branch_count       = 4;
    // One extra outcome at lowest priority stands for "no jump"
    localparam int unsigned outcome_count      = branch_count + 1;
    localparam int unsigned wb_data_width      = 32;
    localparam int unsigned wb_addr_width      = 4;
    localparam int unsigned field_width        = 2;
    localparam int unsigned branch_index_width = wb_addr_width - field_width;
    localparam int unsigned cond_width         = 3;

    // --------------------
    // Register map
    // Upper address bits pick the branch, the lower two pick the field
    localparam logic [field_width-1:0] field_origin      = 2'd0;
    localparam logic [field_width-1:0] field_destination = 2'd1;
    localparam logic [field_width-1:0] field_control     = 2'd2;
    // Control field layout, the condition sits in the low bits
    localparam int unsigned ctrl_enable_bit  = 4;
    localparam int unsigned ctrl_predict_bit = 3;

    // --------------------
    // Condition opcodes, each tests one flag or its inverse
    typedef enum logic [cond_width-1:0] {
        cond_always,
        cond_zero,
        cond_not_zero,
        cond_negative,
        cond_not_negative,
        cond_carry,
        cond_not_carry,
        cond_overflow
    } cond_e;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } alu_flags_t;

    // One branch descriptor as written by software
    typedef struct packed {
        logic                enable;
        logic                predict_taken;
        cond_e               condition;
        logic [pc_width-1:0] origin;
        logic [pc_width-1:0] destination;
    } branch_cfg_t;

    // Outcome of one detector
    typedef struct packed {
        logic                jump;
        logic                cancel;
        logic [pc_width-1:0] destination;
    } branch_req_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [wb_addr_width-1:0] adr;
        logic [wb_data_width-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [wb_data_width-1:0] dat;
    } wb_rsp_t;

endpackage

/* hdl/branch_unit.sv */
// Top level of the branch unit
// Wishbone descriptor block, one detector per branch and the arbiter
// Outputs follow pc and flags by exactly one clock

`timescale 1ns/100ps

module branch_unit (
    input  logic                            clock,
    input  logic                            arst_n,
    input  branch_pkg::wb_req_t             wb_req,
    output branch_pkg::wb_rsp_t             wb_rsp,
    input  logic [branch_pkg::pc_width-1:0] pc,
    input  branch_pkg::alu_flags_t          flags,
    output logic                            jump,
    output logic                            cancel,
    output logic [branch_pkg::pc_width-1:0] jump_destination
);

    // --------------------
    // Descriptor registers
    branch_pkg::branch_cfg_t cfgs [branch_pkg::branch_count];
    branch_pkg::branch_req_t reqs [branch_pkg::branch_count];

    branch_config u_config (
        .clock  (clock),
        .arst_n (arst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cfgs   (cfgs)
    );

    // --------------------
    // Detectors
    // All detectors see the same pc and flags and work in parallel
    for (genvar i = 0; i < branch_pkg::branch_count; i++) begin : g_detector
        branch_detector u_detector (
            .cfg   (cfgs[i]),
            .pc    (pc),
            .flags (flags),
            .req   (reqs[i])
        );
    end

    // --------------------
    // Arbiter
    // Index 0 has the highest priority
    branch_arbiter u_arbiter (
        .clock            (clock),
        .arst_n           (arst_n),
        .reqs             (reqs),
        .jump             (jump),
        .cancel           (cancel),
        .jump_destination (jump_destination)
    );

endmodule

/* test/branch_unit_model.svh */
// Reference model and Wishbone bus tasks for the branch unit testbench
// Included into the testbench module and uses its clock and bus signals

`ifndef BRANCH_UNIT_MODEL_SVH
`define BRANCH_UNIT_MODEL_SVH

// --------------------
// Reference model

// Result of one condition opcode for the given ALU flags
function automatic logic condition_holds(input branch_pkg::cond_e condition,
                                         input branch_pkg::alu_flags_t alu);
    case (condition)
        branch_pkg::cond_always:       return 1'b1;
        branch_pkg::cond_zero:         return alu.zero;
        branch_pkg::cond_not_zero:     return !alu.zero;
        branch_pkg::cond_negative:     return alu.negative;
        branch_pkg::cond_not_negative: return !alu.negative;
        branch_pkg::cond_carry:        return alu.carry;
        branch_pkg::cond_not_carry:    return !alu.carry;
        branch_pkg::cond_overflow:     return alu.overflow;
        default:                       return 1'b0;
    endcase
endfunction

// Expected jump, cancel and destination for one pc and flag vector
function automatic branch_pkg::branch_req_t predict_branch(
    input branch_pkg::branch_cfg_t [branch_pkg::branch_count-1:0] descriptors,
    input logic [branch_pkg::pc_width-1:0]                        current_pc,
    input branch_pkg::alu_flags_t                                 current_flags
);
    branch_pkg::branch_req_t outcome;
    logic                    at_origin;
    logic                    taken;
    logic                    any_mispredict;
    outcome        = '0;
    any_mispredict = 1'b0;
    for (int i = 0; i < branch_pkg::branch_count; i++) begin
        at_origin = descriptors[i].enable && (current_pc == descriptors[i].origin);
        taken     = condition_holds(descriptors[i].condition, current_flags);
        if (at_origin && (taken != descriptors[i].predict_taken)) begin
            any_mispredict = 1'b1;
        end
        // Lowest index wins, so only the first taken branch counts
        if (at_origin && taken && !outcome.jump) begin
            outcome.jump        = 1'b1;
            outcome.cancel      = !descriptors[i].predict_taken;
            outcome.destination = descriptors[i].destination;
        end
    end
    // With no jump, any misprediction still kills the concurrent instruction
    if (!outcome.jump) begin
        outcome.cancel = any_mispredict;
    end
    return outcome;
endfunction

// --------------------
// Wishbone classic master

// One access, entered and left on a falling edge
task automatic wb_access(input logic we, input logic [3:0] adr,
                         input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    wb_req = {1'b1, 1'b1, we, adr, wdata};
    waited = 0;
    // At least one rising edge must pass, so an old ack is never taken
    do begin
        @(negedge clock);
        waited++;
    end while (!wb_rsp.ack && waited < 4);
    rdata  = wb_rsp.dat;
    wb_req = '0;
    if (!wb_rsp.ack) begin
        $display("No Wishbone ack within 4 cycles at address 0x%h", adr);
        halt_run();
    end
endtask

task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
endtask

task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, '0, data);
endtask

`endif

/* test/branch_unit_tb.sv */
// Testbench for the branch unit
// Clock, reset, Wishbone stimulus and pc and flag vectors
// A comparing process checks every cycle against the reference model

`timescale 1ns/100ps

module branch_unit_tb;

    localparam int clock_period    = 20;
    localparam int trials          = 16;
    localparam int random_vectors  = 2000;
    // Accesses and vectors of each test, in the order they run
    localparam int access_count    = 3 * 16 + 4 + 16 * 4 + trials * 12 + random_vectors / 10;
    localparam int vector_count    = 16 * 16 + trials * 16 + random_vectors;
    localparam int watchdog_cycles = access_count * 4 + vector_count + 50;

    logic                                                 clock;
    logic                                                 arst_n;
    branch_pkg::wb_req_t                                  wb_req;
    branch_pkg::wb_rsp_t                                  wb_rsp;
    logic [branch_pkg::pc_width-1:0]                      pc;
    branch_pkg::alu_flags_t                               flags;
    logic                                                 jump;
    logic                                                 cancel;
    logic [branch_pkg::pc_width-1:0]                      jump_destination;
    // Descriptors as the detectors see them, and the raw words last written
    branch_pkg::branch_cfg_t [branch_pkg::branch_count-1:0] shadow;
    logic [31:0]                                          written [16];

    branch_unit dut (
        .clock            (clock),
        .arst_n           (arst_n),
        .wb_req           (wb_req),
        .wb_rsp           (wb_rsp),
        .pc               (pc),
        .flags            (flags),
        .jump             (jump),
        .cancel           (cancel),
        .jump_destination (jump_destination)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    task automatic halt_run;
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            halt_run();
        end
    endtask

    `include "branch_unit_model.svh"

    // Bits of each field that read back, field 3 reads as zero
    function automatic logic [31:0] readback_mask(input logic [1:0] field);
        case (field)
            branch_pkg::field_origin:      return (32'd1 << branch_pkg::pc_width) - 1;
            branch_pkg::field_destination: return (32'd1 << branch_pkg::pc_width) - 1;
            branch_pkg::field_control:     return 32'h1f;
            default:                       return 32'h0;
        endcase
    endfunction

    // Writes one field and mirrors it once the ack shows the write landed
    task automatic program_field(input int adr, input logic [31:0] data);
        wb_write(4'(adr), data);
        written[adr] = data;
        case (adr % 4)
            0: shadow[adr / 4].origin = data[branch_pkg::pc_width-1:0];
            1: shadow[adr / 4].destination = data[branch_pkg::pc_width-1:0];
            2: begin
                shadow[adr / 4].enable        = data[4];
                shadow[adr / 4].predict_taken = data[3];
                shadow[adr / 4].condition     = branch_pkg::cond_e'(data[2:0]);
            end
            default: begin
            end
        endcase
    endtask

    task automatic apply_vector(input logic [9:0] next_pc, input logic [3:0] next_flags);
        pc    = next_pc;
        flags = branch_pkg::alu_flags_t'(next_flags);
        @(negedge clock);
    endtask

    // --------------------
    // Stimulus
    initial begin : stimulus
        int unsigned seed_draw;
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [9:0]  origin;
        int          a;
        int          b;
        seed_draw = $urandom(32482);
        wb_req    = '0;
        pc        = '0;
        flags     = '0;
        shadow    = '0;
        arst_n    = 1'b0;
        repeat (4) @(negedge clock);
        arst_n = 1'b1;
        check_value("jump", jump, 0);
        check_value("cancel", cancel, 0);
        check_value("jump_destination", jump_destination, 0);
        check_value("wb_rsp.ack", wb_rsp.ack, 0);
        for (a = 0; a < 16; a++) begin
            wb_read(4'(a), rdata);
            check_value("wb_rsp.dat", rdata, 0);
        end

        // Register read back, zero-extended
        for (a = 0; a < 16; a++) begin
            program_field(a, $urandom);
        end
        for (a = 0; a < 16; a++) begin
            wb_read(4'(a), rdata);
            check_value("wb_rsp.dat", rdata, written[a] & readback_mask(2'(a)));
        end

        // Every opcode and prediction on one branch, all other branches off
        for (b = 0; b < 4; b++) begin
            program_field(b * 4 + 2, 0);
        end
        for (int c = 0; c < 8; c++) begin
            for (int p = 0; p < 2; p++) begin
                b      = (c * 2 + p) % 4;
                origin = 10'($urandom);
                program_field(b * 4, origin);
                program_field(b * 4 + 1, $urandom);
                program_field(b * 4 + 2, 32'h10 | (p << 3) | c);
                for (int f = 0; f < 16; f++) begin
                    apply_vector(origin, 4'(f));
                end
                program_field(b * 4 + 2, 0);
            end
        end

        // All branches share one origin, with random enables and conditions
        for (int t = 0; t < trials; t++) begin
            origin = 10'($urandom);
            for (b = 0; b < 4; b++) begin
                program_field(b * 4, origin);
                program_field(b * 4 + 1, $urandom);
                program_field(b * 4 + 2, $urandom % 32);
            end
            for (int f = 0; f < 16; f++) begin
                apply_vector(origin, 4'(f));
            end
        end

        // Random vectors back to back, with a random rewrite every 10
        for (int v = 0; v < random_vectors; v++) begin
            if (v % 10 == 0) begin
                a     = $urandom % 16;
                wdata = $urandom;
                // Origins stay in a small window so random pcs often hit them
                if (a % 4 == 0) begin
                    wdata = wdata % 16;
                end
                program_field(a, wdata);
            end
            apply_vector(10'($urandom % 16), 4'($urandom));
        end
        repeat (2) @(negedge clock);
        $display("Simulation PASSED");
        $finish;
    end

    // --------------------
    // Compare with the reference one cycle after the inputs were sampled
    initial begin : compare
        branch_pkg::branch_req_t expected;
        @(posedge arst_n);
        forever begin
            @(posedge clock);
            expected = predict_branch(shadow, pc, flags);
            @(negedge clock);
            check_value("jump", jump, expected.jump);
            check_value("cancel", cancel, expected.cancel);
            check_value("jump_destination", jump_destination, expected.destination);
        end
    end

    initial begin : watchdog
        #(watchdog_cycles * clock_period);
        $display("Watchdog expired before the tests finished");
        halt_run();
    end

endmodule
